// ==== fm_mmr.f ====
source/fm_mmr_pkg.sv
source/fm_prescaler.sv
source/fm_bus_port.sv
source/fm_global_regs.sv
source/fm_ch3_fnum.sv
source/fm_update_decode.sv
source/fm_mmr_top.sv
tests/fm_mmr_assert.sv
tests/fm_mmr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the FM register front end testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module fm_mmr_tb -f fm_mmr.f -o fm_mmr_sim
./obj_dir/fm_mmr_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

// ==== source/fm_bus_port.sv ====
// Host bus port
// Registers the host inputs, keeps the register select and part bit,
// issues one write event per data write and models the busy flag
`timescale 1ns/1ns

module fm_bus_port import fm_mmr_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       write,
    input  logic [1:0] addr,
    input  byte_t      din,
    input  logic       clk_en,
    output wr_event_t  wr_ev,
    output logic       busy
);

    logic                  write_q;
    logic                  write_qq;   // Previous write, for edge detect
    logic [1:0]            addr_q;
    byte_t                 din_q;
    reg_addr_t             sel;
    logic                  part;
    logic [BUSY_CNT_W-1:0] busy_cnt;
    logic                  data_wr;

    assign data_wr = write_q && !write_qq && addr_q[0];

    // Input stage
    always_ff @(posedge clk) begin
        if (rst) begin
            write_q  <= 1'b0;
            write_qq <= 1'b0;
        end else begin
            write_q  <= write;
            write_qq <= write_q;
        end
        addr_q <= addr;
        din_q  <= din;
    end

    // Address cycle latches the register number
    always_ff @(posedge clk) begin
        if (rst) begin
            sel  <= '0;
            part <= 1'b0;
        end else if (write_q && !addr_q[0]) begin
            sel  <= din_q;
            part <= addr_q[1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ev.valid <= 1'b0;
        end else begin
            wr_ev.valid <= data_wr;
        end
        if (data_wr) begin
            wr_ev.addr <= sel;
            wr_ev.part <= part;
            wr_ev.data <= din_q;
        end
    end

    // Busy holds for BUSY_ENABLES synth enables, restarted by every data write
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;
            busy_cnt <= '0;
        end else if (clk_en && busy) begin
            if (busy_cnt == BUSY_CNT_W'(BUSY_ENABLES - 1)) busy <= 1'b0;
            busy_cnt <= busy_cnt + 1'b1;   // Wraps back to zero
        end
    end

endmodule

// ==== source/fm_ch3_fnum.sv ====
// Channel 3 special mode frequencies
// One frequency-high latch shared by all channels feeds the three
// per-operator fnum/block registers
`timescale 1ns/1ns

module fm_ch3_fnum import fm_mmr_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  wr_event_t wr_ev,
    output ch3_freq_t ch3_op1,
    output ch3_freq_t ch3_op2,
    output ch3_freq_t ch3_op3
);

    logic [5:0] fnum_hi;    // Block and fnum bits 10:8
    ch3_freq_t  new_freq;

    always_comb begin
        new_freq.block = fnum_hi[5:3];
        new_freq.fnum  = {fnum_hi[2:0], wr_ev.data};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fnum_hi <= '0;
            ch3_op1 <= '0;
            ch3_op2 <= '0;
            ch3_op3 <= '0;
        end else if (wr_ev.valid) begin
            case (wr_ev.addr)
                // Channel and ch3 operator high bytes, either part
                8'hA4, 8'hA5, 8'hA6, 8'hAC, 8'hAD, 8'hAE: fnum_hi <= wr_ev.data[5:0];
                REG_CH3_OP1: ch3_op1 <= new_freq;
                REG_CH3_OP2: ch3_op2 <= new_freq;
                REG_CH3_OP3: ch3_op3 <= new_freq;
                default: ;
            endcase
        end
    end

endmodule

// ==== source/fm_global_regs.sv ====
// Global register decoder
// Timers, LFO, test bits, clock divider and DAC sample for part 0
`timescale 1ns/1ns

module fm_global_regs import fm_mmr_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  wr_event_t  wr_ev,
    output timer_cfg_t timer,
    output logic       clr_flag_a,
    output logic       clr_flag_b,
    output logic       lfo_en,
    output logic [2:0] lfo_freq,
    output logic       eg_stop,
    output logic       pg_stop,
    output logic       effect,
    output logic       csm,
    output div_sel_t   div,
    output logic [8:0] pcm,
    output logic       pcm_en,
    output logic       pcm_wr
);

    logic  part0_wr;
    byte_t d;

    assign part0_wr = wr_ev.valid && !wr_ev.part;
    assign d        = wr_ev.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            timer      <= '0;
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            lfo_en     <= 1'b0;
            lfo_freq   <= '0;
            eg_stop    <= 1'b0;
            pg_stop    <= 1'b0;
            effect     <= 1'b0;
            csm        <= 1'b0;
            div        <= DIV_BY6;
            pcm        <= '0;
            pcm_en     <= 1'b0;
            pcm_wr     <= 1'b0;
        end else begin
            // Strobes last a single clock
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            pcm_wr     <= 1'b0;
            if (part0_wr) begin
                case (wr_ev.addr)
                    REG_TESTYM: begin
                        eg_stop           <= d[5];
                        pg_stop           <= d[3];
                        timer.fast_timers <= d[2];
                    end
                    REG_LFO:   {lfo_en, lfo_freq} <= d[3:0];
                    REG_CLKA1: timer.value_a[9:2] <= d;       // Upper bits of timer A
                    REG_CLKA2: timer.value_a[1:0] <= d[1:0];
                    REG_CLKB:  timer.value_b      <= d;
                    REG_TIMER: begin
                        effect <= |d[7:6];
                        csm    <= (d[7:6] == 2'b10);
                        {clr_flag_b, clr_flag_a, timer.irq_en_b, timer.irq_en_a,
                         timer.load_b, timer.load_a} <= d[5:0];
                    end
                    REG_CLK_N6: div[1] <= 1'b1;
                    REG_CLK_N3: div[0] <= 1'b1;
                    REG_CLK_N2: div    <= DIV_BY2;
                    REG_PCM: begin
                        pcm    <= {~d[7], d[6:0], 1'b1};  // Offset binary to signed
                        pcm_wr <= 1'b1;
                    end
                    REG_DACTEST: pcm[0] <= d[3];
                    REG_PCM_EN:  pcm_en <= d[7];
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== source/fm_mmr_pkg.sv ====
// FM register front end shared definitions
// Register map, field widths, update kinds and the internal bus structs
package fm_mmr_pkg;

    typedef logic [7:0]  reg_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [10:0] fnum_t;
    typedef logic [2:0]  block_t;
    typedef logic [2:0]  ch_sel_t;   // Part bit over channel number
    typedef logic [1:0]  op_sel_t;
    typedef logic [1:0]  div_sel_t;

    // Global register addresses
    localparam reg_addr_t REG_TESTYM  = 8'h21;
    localparam reg_addr_t REG_LFO     = 8'h22;
    localparam reg_addr_t REG_CLKA1   = 8'h24;
    localparam reg_addr_t REG_CLKA2   = 8'h25;
    localparam reg_addr_t REG_CLKB    = 8'h26;
    localparam reg_addr_t REG_TIMER   = 8'h27;
    localparam reg_addr_t REG_KON     = 8'h28;
    localparam reg_addr_t REG_PCM     = 8'h2A;
    localparam reg_addr_t REG_PCM_EN  = 8'h2B;
    localparam reg_addr_t REG_DACTEST = 8'h2C;
    localparam reg_addr_t REG_CLK_N6  = 8'h2D;
    localparam reg_addr_t REG_CLK_N3  = 8'h2E;
    localparam reg_addr_t REG_CLK_N2  = 8'h2F;
    localparam reg_addr_t REG_CH3_OP1 = 8'hA9;
    localparam reg_addr_t REG_CH3_OP3 = 8'hA8;
    localparam reg_addr_t REG_CH3_OP2 = 8'hAA;

    localparam div_sel_t DIV_BY6 = 2'b11;   // Reset setting
    localparam div_sel_t DIV_BY2 = 2'b00;

    localparam int BUSY_ENABLES = 32;
    localparam int BUSY_CNT_W   = $clog2(BUSY_ENABLES);

    typedef enum logic [3:0] {
        UPD_NONE, UPD_FNUM_LO, UPD_ALG, UPD_PMS,
        UPD_DT1_MUL, UPD_TL, UPD_KS_AR, UPD_AMEN_DR,
        UPD_SR, UPD_SL_RR, UPD_SSGEG, UPD_KEYON
    } upd_kind_e;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        logic      part;
        byte_t     data;
    } wr_event_t;

    typedef struct packed {
        logic      valid;
        upd_kind_e kind;
        ch_sel_t   ch;
        op_sel_t   op;
        byte_t     data;
    } reg_update_t;

    typedef struct packed {
        logic [9:0] value_a;
        logic [7:0] value_b;
        logic       load_a;
        logic       load_b;
        logic       irq_en_a;
        logic       irq_en_b;
        logic       fast_timers;
    } timer_cfg_t;

    typedef struct packed {
        fnum_t  fnum;
        block_t block;
    } ch3_freq_t;

endpackage

// ==== source/fm_mmr_top.sv ====
// FM sound chip register front end
// Host port, global and channel-3 registers, update events and synth prescaler
`timescale 1ns/1ns

module fm_mmr_top import fm_mmr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        write,
    input  logic [1:0]  addr,
    input  byte_t       din,
    output logic        clk_en,
    output logic        busy,
    output timer_cfg_t  timer,
    output logic        clr_flag_a,
    output logic        clr_flag_b,
    output logic        lfo_en,
    output logic [2:0]  lfo_freq,
    output logic        eg_stop,
    output logic        pg_stop,
    output logic        effect,
    output logic        csm,
    output div_sel_t    div,
    output logic [8:0]  pcm,
    output logic        pcm_en,
    output logic        pcm_wr,
    output ch3_freq_t   ch3_op1,
    output ch3_freq_t   ch3_op2,
    output ch3_freq_t   ch3_op3,
    output reg_update_t upd
);

    wr_event_t wr_ev;   // Shared by all decoders

    fm_prescaler u_presc (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .div    (div),
        .clk_en (clk_en)
    );

    fm_bus_port u_port (
        .clk    (clk),
        .rst    (rst),
        .write  (write),
        .addr   (addr),
        .din    (din),
        .clk_en (clk_en),
        .wr_ev  (wr_ev),
        .busy   (busy)
    );

    fm_global_regs u_global (
        .clk        (clk),
        .rst        (rst),
        .wr_ev      (wr_ev),
        .timer      (timer),
        .clr_flag_a (clr_flag_a),
        .clr_flag_b (clr_flag_b),
        .lfo_en     (lfo_en),
        .lfo_freq   (lfo_freq),
        .eg_stop    (eg_stop),
        .pg_stop    (pg_stop),
        .effect     (effect),
        .csm        (csm),
        .div        (div),
        .pcm        (pcm),
        .pcm_en     (pcm_en),
        .pcm_wr     (pcm_wr)
    );

    fm_ch3_fnum u_ch3 (
        .clk     (clk),
        .rst     (rst),
        .wr_ev   (wr_ev),
        .ch3_op1 (ch3_op1),
        .ch3_op2 (ch3_op2),
        .ch3_op3 (ch3_op3)
    );

    fm_update_decode u_upd (
        .clk   (clk),
        .rst   (rst),
        .wr_ev (wr_ev),
        .upd   (upd)
    );

endmodule

// ==== source/fm_prescaler.sv ====
// Synth clock prescaler
// Divides the incoming clock enable by 6, 3 or 2 per the divider registers
`timescale 1ns/1ns

module fm_prescaler import fm_mmr_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     cen,
    input  div_sel_t div,
    output logic     clk_en
);

    logic [2:0] cnt;
    logic [2:0] last;       // Terminal count of the running period
    logic [2:0] next_last;

    always_comb begin
        case (div)
            2'b00:   next_last = 3'd1;   // Divide by 2
            2'b01:   next_last = 3'd2;   // Divide by 3
            default: next_last = 3'd5;
        endcase
    end

    assign clk_en = cen && (cnt == last);

    // New setting is picked up only at the wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            last <= 3'd5;
        end else if (cen) begin
            if (cnt == last) begin
                cnt  <= '0;
                last <= next_last;
            end else begin
                cnt <= cnt + 3'd1;
            end
        end
    end

endmodule

// ==== source/fm_update_decode.sv ====
// Channel and operator update decoder
// Turns each data write into a one-clock update event for the register file
`timescale 1ns/1ns

module fm_update_decode import fm_mmr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  wr_event_t   wr_ev,
    output reg_update_t upd
);

    upd_kind_e kind;

    always_comb begin
        kind = UPD_NONE;
        if (wr_ev.addr == REG_KON) begin
            kind = UPD_KEYON;
        end else if (wr_ev.addr[1:0] != 2'b11) begin   // Slot 3 does not exist
            case (wr_ev.addr[7:4])
                4'h3: kind = UPD_DT1_MUL;
                4'h4: kind = UPD_TL;
                4'h5: kind = UPD_KS_AR;
                4'h6: kind = UPD_AMEN_DR;
                4'h7: kind = UPD_SR;
                4'h8: kind = UPD_SL_RR;
                4'h9: kind = UPD_SSGEG;
                4'hA: if (wr_ev.addr[3:2] == 2'b00) kind = UPD_FNUM_LO;
                4'hB: begin
                    if (wr_ev.addr[3:2] == 2'b00) kind = UPD_ALG;
                    else if (wr_ev.addr[3:2] == 2'b01) kind = UPD_PMS;
                end
                default: kind = UPD_NONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            upd <= '0;
        end else begin
            upd.valid <= wr_ev.valid;
            upd.kind  <= kind;
            upd.ch    <= {wr_ev.part, wr_ev.addr[1:0]};
            upd.op    <= wr_ev.addr[3:2];      // Slot order S1, S3, S2, S4
            upd.data  <= wr_ev.data;
        end
    end

endmodule

// ==== tests/fm_mmr_assert.sv ====
// Bound checks on the register front end
// Strobes are single-clock pulses and busy starts low out of reset
`timescale 1ns/1ns

module fm_mmr_assert (
    input logic clk,
    input logic rst,
    input logic pcm_wr,
    input logic clr_flag_a,
    input logic upd_valid,
    input logic busy
);

    int assert_fails = 0;   // Read by the testbench at the end

    pcm_wr_single: assert property (@(posedge clk) disable iff (rst) pcm_wr |=> !pcm_wr)
        else begin
            $error("pcm_wr high for two clocks");
            assert_fails++;
        end

    clr_a_single: assert property (@(posedge clk) disable iff (rst) clr_flag_a |=> !clr_flag_a)
        else begin
            $error("clr_flag_a high for two clocks");
            assert_fails++;
        end

    upd_single: assert property (@(posedge clk) disable iff (rst) upd_valid |=> !upd_valid)
        else begin
            $error("upd.valid high for two clocks");
            assert_fails++;
        end

    // Busy starts low
    busy_reset: assert property (@(posedge clk) rst |=> !busy)
        else begin
            $error("busy high after reset");
            assert_fails++;
        end

endmodule

bind fm_mmr_top fm_mmr_assert u_chk (
    .clk        (clk),
    .rst        (rst),
    .pcm_wr     (pcm_wr),
    .clr_flag_a (clr_flag_a),
    .upd_valid  (upd.valid),
    .busy       (busy)
);

// ==== tests/fm_mmr_tb.sv ====
// Testbench for the FM register front end
// Directed tests over timers, global bits, channel-3 frequencies,
// update events, prescaler and busy
`timescale 1ns/1ns

module fm_mmr_tb import fm_mmr_pkg::*; ();

    // Update sweep is about 272 writes at 7 cycles, the rest stays under 500
    localparam int MAX_CYCLES = 3000;

    logic        clk = 1'b0;
    logic        rst;
    logic        cen;
    logic        write;
    logic [1:0]  addr;
    byte_t       din;
    logic        clk_en, busy, clr_flag_a, clr_flag_b, lfo_en, eg_stop, pg_stop;
    logic        effect, csm, pcm_en, pcm_wr;
    logic [2:0]  lfo_freq;
    logic [8:0]  pcm;
    div_sel_t    div;
    timer_cfg_t  timer;
    ch3_freq_t   ch3_op1, ch3_op2, ch3_op3;
    reg_update_t upd;

    int          cycles = 0;
    int          test_errs = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          seed = 32'he556_1487;
    string       test_name;
    logic [2:0]  clr_a_hist, clr_b_hist, pcm_wr_hist, upd_hist;  // Three cycles after a write
    reg_update_t upd_seen;

    fm_mmr_top uut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Drive and sample point, 10 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic check_val(input string what, input logic [63:0] exp_val,
                             input logic [63:0] act);
        assert (exp_val == act) else begin
            $display("ERROR %s: %s expected %0h, actual %0h", test_name, what, exp_val, act);
            test_errs++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            pass_count++;
            $display("Test %s passed", test_name);
        end else begin
            fail_count++;
            $display("Test %s failed with %0d errors", test_name, test_errs);
        end
    endtask

    // Address cycle, idle cycle, then the data cycle
    task automatic write_reg(input logic part, input reg_addr_t ra, input byte_t data);
        step();
        write = 1'b1;
        addr  = {part, 1'b0};
        din   = ra;
        step();
        write = 1'b0;
        step();
        write = 1'b1;
        addr  = {part, 1'b1};
        din   = data;
        step();
        write = 1'b0;
    endtask

    // Results land in the middle one of these three cycles
    task automatic settle_write();
        for (int i = 0; i < 3; i++) begin
            step();
            clr_a_hist[i]  = clr_flag_a;
            clr_b_hist[i]  = clr_flag_b;
            pcm_wr_hist[i] = pcm_wr;
            upd_hist[i]    = upd.valid;
            if (i == 1) upd_seen = upd;
        end
    endtask

    task automatic write_settled(input logic part, input reg_addr_t ra, input byte_t data);
        write_reg(part, ra, data);
        settle_write();
    endtask

    // Update group straight from the register map
    function automatic upd_kind_e expected_kind(input reg_addr_t ra);
        if (ra == 8'h28) return UPD_KEYON;
        if (ra[1:0] == 2'b11) return UPD_NONE;
        if (ra >= 8'hA0 && ra <= 8'hA2) return UPD_FNUM_LO;
        if (ra >= 8'hB0 && ra <= 8'hB2) return UPD_ALG;
        if (ra >= 8'hB4 && ra <= 8'hB6) return UPD_PMS;
        if (ra[7:4] >= 4'h3 && ra[7:4] <= 4'h9)
            return upd_kind_e'(UPD_DT1_MUL + (ra[7:4] - 4'h3));
        return UPD_NONE;
    endfunction

    function automatic ch3_freq_t freq_of(input byte_t hi, input byte_t lo);
        ch3_freq_t f;
        f.block = hi[5:3];
        f.fnum  = {hi[2:0], lo};
        return f;
    endfunction

    // Cycles from one clk_en pulse to the next, 20 means none came
    task automatic clk_en_interval(output int gap);
        int n;
        n = 0;
        while (!clk_en && n < 20) begin
            step();
            n++;
        end
        step();
        gap = 1;
        while (!clk_en && gap < 20) begin
            step();
            gap++;
        end
    endtask

    task automatic reset_state();
        start_test("reset");
        check_val("busy", 0, busy);
        check_val("clk_en", 0, clk_en);
        check_val("strobes and upd.valid", 0, {clr_flag_a, clr_flag_b, pcm_wr, upd.valid});
        check_val("div", 2'b11, div);
        check_val("timer", 0, timer);
        check_val("pcm", 0, pcm);
        check_val("held bits", 0, {lfo_en, lfo_freq, eg_stop, pg_stop, effect, csm, pcm_en});
        check_val("ch3 freqs", 0, {ch3_op1, ch3_op2, ch3_op3});
        finish_test();
    endtask

    task automatic timers();
        byte_t ctls[2] = '{8'h95, 8'h6A};   // CSM with clear A, then effect with clear B
        start_test("timers");
        write_settled(1'b0, REG_CLKA1, 8'hB5);
        write_settled(1'b0, REG_CLKA2, 8'hFE);
        write_settled(1'b0, REG_CLKB, 8'h9C);
        check_val("value_a", {8'hB5, 2'b10}, timer.value_a);
        check_val("value_b", 8'h9C, timer.value_b);
        foreach (ctls[i]) begin
            write_settled(1'b0, REG_TIMER, ctls[i]);
            check_val("load and irq bits", {ctls[i][0], ctls[i][1], ctls[i][2], ctls[i][3]},
                      {timer.load_a, timer.load_b, timer.irq_en_a, timer.irq_en_b});
            check_val("effect", ctls[i][7] | ctls[i][6], effect);
            check_val("csm", ctls[i][7] & ~ctls[i][6], csm);
            check_val("clr_flag_a cycles", ctls[i][4] ? 3'b010 : 3'b000, clr_a_hist);
            check_val("clr_flag_b cycles", ctls[i][5] ? 3'b010 : 3'b000, clr_b_hist);
        end
        finish_test();
    endtask

    task automatic misc_globals();
        byte_t pcm_d;
        pcm_d = byte_t'($random(seed));
        start_test("globals");
        write_settled(1'b0, REG_LFO, 8'h0D);
        check_val("lfo_en and rate", {1'b1, 3'd5}, {lfo_en, lfo_freq});
        write_settled(1'b1, REG_LFO, 8'h00);   // Part 1 is ignored
        check_val("lfo_en after part 1 write", 1, lfo_en);
        write_settled(1'b0, REG_TESTYM, 8'h2C);
        check_val("eg_stop pg_stop fast_timers", 3'b111, {eg_stop, pg_stop, timer.fast_timers});
        write_settled(1'b0, REG_PCM_EN, 8'h80);
        check_val("pcm_en", 1, pcm_en);
        write_settled(1'b0, REG_PCM, pcm_d);
        check_val("pcm", {~pcm_d[7], pcm_d[6:0], 1'b1}, pcm);
        check_val("pcm_wr cycles", 3'b010, pcm_wr_hist);
        write_settled(1'b0, REG_DACTEST, 8'h00);
        check_val("pcm bit 0 cleared", {~pcm_d[7], pcm_d[6:0], 1'b0}, pcm);
        write_settled(1'b0, REG_DACTEST, 8'h08);
        check_val("pcm bit 0 set", 1, pcm[0]);
        finish_test();
    endtask

    task automatic ch3_freqs();
        start_test("ch3_freqs");
        write_settled(1'b0, 8'hA4, 8'h2D);
        write_settled(1'b0, REG_CH3_OP1, 8'h11);
        write_settled(1'b0, REG_CH3_OP2, 8'h22);
        write_settled(1'b1, 8'hAD, 8'h1A);     // Latch through part 1
        write_settled(1'b0, REG_CH3_OP3, 8'h33);
        check_val("ch3_op1", freq_of(8'h2D, 8'h11), ch3_op1);
        check_val("ch3_op2", freq_of(8'h2D, 8'h22), ch3_op2);
        check_val("ch3_op3", freq_of(8'h1A, 8'h33), ch3_op3);
        finish_test();
    endtask

    task automatic update_one(input logic part, input reg_addr_t ra);
        reg_update_t exp_upd;
        byte_t       d;
        d             = ra ^ {part, 7'h35};
        exp_upd.valid = 1'b1;
        exp_upd.kind  = expected_kind(ra);
        exp_upd.ch    = {part, ra[1:0]};
        exp_upd.op    = ra[3:2];
        exp_upd.data  = d;
        write_settled(part, ra, d);
        check_val($sformatf("upd for %0d:%02h", part, ra), exp_upd, upd_seen);
        check_val($sformatf("upd.valid cycles for %0d:%02h", part, ra), 3'b010, upd_hist);
    endtask

    task automatic update_events();
        start_test("update_events");
        for (int p = 0; p < 2; p++) begin
            update_one(p[0], REG_KON);
            for (int a = 'h30; a <= 'hB6; a++) update_one(p[0], reg_addr_t'(a));
        end
        finish_test();
    endtask

    task automatic prescaler_busy();
        int   gap;
        int   pulses;
        int   n;
        logic last_en;
        start_test("prescaler_busy");
        clk_en_interval(gap);
        clk_en_interval(gap);
        check_val("clk_en interval after reset", 6, gap);
        write_settled(1'b0, REG_CLK_N2, 8'h00);
        clk_en_interval(gap);
        clk_en_interval(gap);
        check_val("clk_en interval after 2Fh", 2, gap);
        write_settled(1'b0, REG_CLK_N3, 8'h00);
        clk_en_interval(gap);
        clk_en_interval(gap);
        check_val("clk_en interval after 2Eh", 3, gap);
        cen = 1'b0;
        for (int i = 0; i < 4; i++) begin
            step();
            check_val("clk_en with cen low", 0, clk_en);
        end
        cen = 1'b1;
        n   = 0;
        while (busy && n < 200) begin   // Busy from the divider writes runs out first
            step();
            n++;
        end
        check_val("busy before data write", 0, busy);
        write_reg(1'b0, REG_KON, 8'h00);
        step();
        check_val("busy after data write", 1, busy);
        pulses  = 0;
        last_en = 1'b0;
        n       = 0;
        while (busy && n < 200) begin
            last_en = clk_en;
            if (clk_en) pulses++;
            step();
            n++;
        end
        assert (n < 200) else begin
            $display("%s: busy never dropped within 200 cycles", test_name);
            test_errs++;
        end
        check_val("clk_en pulses during busy", BUSY_ENABLES, pulses);
        check_val("clk_en in last busy cycle", 1, last_en);
        finish_test();
    endtask

    initial begin
        rst   = 1'b1;
        cen   = 1'b1;
        write = 1'b0;
        addr  = 2'b00;
        din   = 8'h00;
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;
        reset_state();
        timers();
        misc_globals();
        ch3_freqs();
        update_events();
        prescaler_busy();
        $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
                 pass_count, fail_count, uut.u_chk.assert_fails);
        if (fail_count == 0 && uut.u_chk.assert_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
